/* Bender.yml */
package:
  name: jesd_rx_up_regs

sources:
  - logic/jesd_rx_regs_pkg.sv
  - logic/lane_status_if.sv
  - logic/rx_status_capture.sv
  - logic/rx_lane_regs.sv
  - logic/rx_common_regs.sv
  - logic/rx_read_mux.sv
  - logic/jesd_rx_up_top.sv
  - target: test
    files:
      - tests/tb_top.sv

/* logic/jesd_rx_regs_pkg.sv */
package jesd_rx_regs_pkg;

  // receive lanes handled by the register block
  localparam int NUM_LANES = 4;
  // bits needed to index one lane
  localparam int LANE_IDX_W = $clog2(NUM_LANES);

  // elastic buffer size in octets, read only
  localparam logic [31:0] ELASTIC_BUFFER_SIZE = 32'd256;

  // common register word addresses
  localparam logic [11:0] ADDR_BUF_SIZE = 12'h010;
  localparam logic [11:0] ADDR_BUF_CFG = 12'h090;
  localparam logic [11:0] ADDR_ERR_STATS = 12'h091;
  localparam logic [11:0] ADDR_ALIGN_THRESH = 12'h092;
  localparam logic [11:0] ADDR_CTRL_STATE = 12'h0a0;

  // address bits 11:3 of lane 0, lane i sits at 0x0c0 + 8*i
  localparam logic [8:0] LANE_BASE_WORD = 9'h018;

  // frame alignment error threshold after reset
  localparam logic [7:0] THRESH_RESET = 8'd4;

  // offsets inside one lane block
  typedef enum logic [2:0] {
    LANE_STATUS = 3'd0,
    LANE_LATENCY = 3'd1,
    LANE_ERR_STATS = 3'd2,
    LANE_ALIGN_ERR = 3'd3,
    LANE_ILAS0 = 3'd4,
    LANE_ILAS1 = 3'd5,
    LANE_ILAS2 = 3'd6,
    LANE_ILAS3 = 3'd7
  } lane_reg_e;

  // link controller FSM state
  typedef enum logic [1:0] {
    RESET = 2'd0,
    WAIT_SYSREF = 2'd1,
    CGS = 2'd2,
    DATA = 2'd3
  } rx_ctrl_state_e;

  // per lane code group sync state, encoding 3 is unused
  typedef enum logic [1:0] {
    CGS_INIT = 2'd0,
    CGS_CHECK = 2'd1,
    CGS_DATA = 2'd2
  } cgs_state_e;

endpackage

/* logic/jesd_rx_up_top.sv */
`timescale 1ns/1ps

module jesd_rx_up_top (
  input logic up_clk,
  input logic up_reset,
  input logic up_rreq,
  input logic [11:0] up_raddr,
  output logic [31:0] up_rdata,
  input logic up_wreq,
  input logic [11:0] up_waddr,
  input logic [31:0] up_wdata,
  input logic cfg_is_writeable,
  output logic cfg_buffer_early_release,
  output logic [7:0] cfg_buffer_delay,
  output logic [8:0] err_stats_mask,
  output logic err_stats_reset,
  output logic [7:0] cfg_align_err_threshold,
  input jesd_rx_regs_pkg::rx_ctrl_state_e status_ctrl_state,
  input logic [2*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_cgs_state,
  input logic [3*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_emb_state,
  input logic [jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_ifs_ready,
  input logic [14*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_latency,
  input logic [8*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_align_err_cnt,
  input logic [32*jesd_rx_regs_pkg::NUM_LANES-1:0] status_err_stats_cnt,
  input logic [jesd_rx_regs_pkg::NUM_LANES-1:0] ilas_valid,
  input logic [2*jesd_rx_regs_pkg::NUM_LANES-1:0] ilas_addr,
  input logic [32*jesd_rx_regs_pkg::NUM_LANES-1:0] ilas_data
);
  import jesd_rx_regs_pkg::*;

  rx_ctrl_state_e ctrl_state;
  logic [31:0] common_rdata;
  logic common_hit;
  logic [31:0] lane_rdata [NUM_LANES];

  lane_status_if lane_st [NUM_LANES] ();

  rx_status_capture i_capture (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .status_ctrl_state(status_ctrl_state),
    .status_lane_cgs_state(status_lane_cgs_state),
    .status_lane_emb_state(status_lane_emb_state),
    .status_lane_ifs_ready(status_lane_ifs_ready),
    .status_lane_latency(status_lane_latency),
    .status_lane_align_err_cnt(status_lane_align_err_cnt),
    .status_err_stats_cnt(status_err_stats_cnt),
    .ilas_valid(ilas_valid),
    .ilas_addr(ilas_addr),
    .ilas_data(ilas_data),
    .ctrl_state(ctrl_state),
    .lanes(lane_st)
  );

  // every lane decodes the low three address bits
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    rx_lane_regs i_lane (
      .up_clk(up_clk),
      .up_reset(up_reset),
      .st(lane_st[i]),
      .raddr(lane_reg_e'(up_raddr[2:0])),
      .rdata(lane_rdata[i])
    );
  end

  rx_common_regs i_common (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .up_wreq(up_wreq),
    .up_waddr(up_waddr),
    .up_wdata(up_wdata),
    .raddr(up_raddr),
    .cfg_is_writeable(cfg_is_writeable),
    .ctrl_state(ctrl_state),
    .cfg_buffer_early_release(cfg_buffer_early_release),
    .cfg_buffer_delay(cfg_buffer_delay),
    .err_stats_mask(err_stats_mask),
    .err_stats_reset(err_stats_reset),
    .cfg_align_err_threshold(cfg_align_err_threshold),
    .rdata(common_rdata),
    .hit(common_hit)
  );

  rx_read_mux i_read_mux (
    .up_clk(up_clk),
    .up_reset(up_reset),
    .up_rreq(up_rreq),
    .up_raddr(up_raddr),
    .common_rdata(common_rdata),
    .common_hit(common_hit),
    .lane_rdata(lane_rdata),
    .up_rdata(up_rdata)
  );

endmodule

/* logic/lane_status_if.sv */
`timescale 1ns/1ps

interface lane_status_if;
  import jesd_rx_regs_pkg::*;

  // status levels, already registered
  cgs_state_e cgs_state;
  logic [2:0] emb_state;
  logic ifs_ready;
  logic [13:0] latency;
  logic [7:0] align_err_cnt;
  logic [31:0] err_stats_cnt;

  // ILAS word write strobe
  logic ilas_valid;
  logic [1:0] ilas_addr;
  logic [31:0] ilas_data;

  modport capture (
    output cgs_state, emb_state, ifs_ready, latency, align_err_cnt,
    output err_stats_cnt, ilas_valid, ilas_addr, ilas_data
  );

  modport lane (
    input cgs_state, emb_state, ifs_ready, latency, align_err_cnt,
    input err_stats_cnt, ilas_valid, ilas_addr, ilas_data
  );

endinterface

/* logic/rx_common_regs.sv */
`timescale 1ns/1ps

module rx_common_regs (
  input logic up_clk,
  input logic up_reset,
  input logic up_wreq,
  input logic [11:0] up_waddr,
  input logic [31:0] up_wdata,
  input logic [11:0] raddr,
  input logic cfg_is_writeable,
  input jesd_rx_regs_pkg::rx_ctrl_state_e ctrl_state,
  output logic cfg_buffer_early_release,
  output logic [7:0] cfg_buffer_delay,
  output logic [8:0] err_stats_mask,
  output logic err_stats_reset,
  output logic [7:0] cfg_align_err_threshold,
  output logic [31:0] rdata,
  output logic hit
);
  import jesd_rx_regs_pkg::*;

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      cfg_buffer_early_release <= 1'b0;
      cfg_buffer_delay <= '0;
      err_stats_mask <= '0;
      err_stats_reset <= 1'b0;
      cfg_align_err_threshold <= THRESH_RESET;
    end else if (up_wreq) begin
      case (up_waddr)
        // buffer config only changes while the link allows it
        ADDR_BUF_CFG: begin
          if (cfg_is_writeable) begin
            cfg_buffer_early_release <= up_wdata[16];
            cfg_buffer_delay <= up_wdata[9:2];
          end
        end
        ADDR_ERR_STATS: begin
          err_stats_mask <= up_wdata[16:8];
          err_stats_reset <= up_wdata[0];
        end
        ADDR_ALIGN_THRESH: begin
          cfg_align_err_threshold <= up_wdata[7:0];
        end
        default: begin
        end
      endcase
    end
  end

  // common read decode, unused bits read as zero
  always_comb begin
    hit = 1'b1;
    case (raddr)
      ADDR_BUF_SIZE: rdata = ELASTIC_BUFFER_SIZE;
      ADDR_BUF_CFG: rdata = {15'h0, cfg_buffer_early_release, 6'h0, cfg_buffer_delay, 2'b00};
      ADDR_ERR_STATS: rdata = {15'h0, err_stats_mask, 7'h0, err_stats_reset};
      ADDR_ALIGN_THRESH: rdata = {24'h0, cfg_align_err_threshold};
      ADDR_CTRL_STATE: rdata = {30'h0, ctrl_state};
      default: begin
        rdata = '0;
        hit = 1'b0;
      end
    endcase
  end

  // without a write, the first cycle out of reset keeps the reset configuration
  a_cfg_reset_values: assert property (@(posedge up_clk)
    ($fell(up_reset) && !up_wreq) |=>
      (!cfg_buffer_early_release && cfg_buffer_delay == 8'd0 &&
       err_stats_mask == 9'd0 && !err_stats_reset &&
       cfg_align_err_threshold == THRESH_RESET));

endmodule

/* logic/rx_lane_regs.sv */
`timescale 1ns/1ps

module rx_lane_regs (
  input logic up_clk,
  input logic up_reset,
  lane_status_if.lane st,
  input jesd_rx_regs_pkg::lane_reg_e raddr,
  output logic [31:0] rdata
);
  import jesd_rx_regs_pkg::*;

  // the four ILAS configuration words sent by the link
  logic [31:0] ilas_mem [4];

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      for (int w = 0; w < 4; w++) begin
        ilas_mem[w] <= '0;
      end
    end else if (st.ilas_valid) begin
      ilas_mem[st.ilas_addr] <= st.ilas_data;
    end
  end

  // lane read decode
  always_comb begin
    case (raddr)
      LANE_STATUS: begin
        rdata = {
          21'h0,
          st.emb_state,
          3'b000,
          st.ifs_ready,
          2'b00,
          st.cgs_state
        };
      end
      LANE_LATENCY: begin
        rdata = {18'h0, st.latency};
      end
      LANE_ERR_STATS: begin
        rdata = st.err_stats_cnt;
      end
      LANE_ALIGN_ERR: begin
        rdata = {24'h0, st.align_err_cnt};
      end
      LANE_ILAS0: begin
        rdata = ilas_mem[0];
      end
      LANE_ILAS1: begin
        rdata = ilas_mem[1];
      end
      LANE_ILAS2: begin
        rdata = ilas_mem[2];
      end
      LANE_ILAS3: begin
        rdata = ilas_mem[3];
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

  // the sync FSM in the link never reaches encoding 3
  a_cgs_state_valid: assert property (@(posedge up_clk) disable iff (up_reset)
    st.cgs_state != 2'd3);

endmodule

/* logic/rx_read_mux.sv */
`timescale 1ns/1ps

module rx_read_mux (
  input logic up_clk,
  input logic up_reset,
  input logic up_rreq,
  input logic [11:0] up_raddr,
  input logic [31:0] common_rdata,
  input logic common_hit,
  input logic [31:0] lane_rdata [jesd_rx_regs_pkg::NUM_LANES],
  output logic [31:0] up_rdata
);
  import jesd_rx_regs_pkg::*;

  logic [8:0] lane_off;
  logic lane_sel;
  logic [31:0] rdata_sel;

  // lane blocks are 8 words each, starting at LANE_BASE_WORD
  assign lane_off = up_raddr[11:3] - LANE_BASE_WORD;
  assign lane_sel = (up_raddr[11:3] >= LANE_BASE_WORD) &&
                    (lane_off < 9'(NUM_LANES));

  always_comb begin
    if (lane_sel) begin
      rdata_sel = lane_rdata[lane_off[LANE_IDX_W-1:0]];
    end else if (common_hit) begin
      rdata_sel = common_rdata;
    end else begin
      rdata_sel = '0;
    end
  end

  // read data holds until the next request
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      up_rdata <= '0;
    end else if (up_rreq) begin
      up_rdata <= rdata_sel;
    end
  end

  // common map and lane window must not overlap
  a_no_overlap: assert property (@(posedge up_clk) disable iff (up_reset)
    !(common_hit && lane_sel));

endmodule

/* logic/rx_status_capture.sv */
`timescale 1ns/1ps

module rx_status_capture (
  input logic up_clk,
  input logic up_reset,
  input jesd_rx_regs_pkg::rx_ctrl_state_e status_ctrl_state,
  input logic [2*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_cgs_state,
  input logic [3*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_emb_state,
  input logic [jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_ifs_ready,
  input logic [14*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_latency,
  input logic [8*jesd_rx_regs_pkg::NUM_LANES-1:0] status_lane_align_err_cnt,
  input logic [32*jesd_rx_regs_pkg::NUM_LANES-1:0] status_err_stats_cnt,
  input logic [jesd_rx_regs_pkg::NUM_LANES-1:0] ilas_valid,
  input logic [2*jesd_rx_regs_pkg::NUM_LANES-1:0] ilas_addr,
  input logic [32*jesd_rx_regs_pkg::NUM_LANES-1:0] ilas_data,
  output jesd_rx_regs_pkg::rx_ctrl_state_e ctrl_state,
  lane_status_if.capture lanes [jesd_rx_regs_pkg::NUM_LANES]
);
  import jesd_rx_regs_pkg::*;

  logic [2*NUM_LANES-1:0] cgs_q;
  logic [3*NUM_LANES-1:0] emb_q;
  logic [NUM_LANES-1:0] ifs_ready_q;
  logic [14*NUM_LANES-1:0] latency_q;
  logic [8*NUM_LANES-1:0] align_err_q;
  logic [32*NUM_LANES-1:0] err_stats_q;
  logic [NUM_LANES-1:0] ilas_valid_q;
  logic [2*NUM_LANES-1:0] ilas_addr_q;
  logic [32*NUM_LANES-1:0] ilas_data_q;

  // one register stage for every status and ILAS input
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      ctrl_state <= RESET;
      cgs_q <= '0;
      emb_q <= '0;
      ifs_ready_q <= '0;
      latency_q <= '0;
      align_err_q <= '0;
      err_stats_q <= '0;
      ilas_valid_q <= '0;
      ilas_addr_q <= '0;
      ilas_data_q <= '0;
    end else begin
      ctrl_state <= status_ctrl_state;
      cgs_q <= status_lane_cgs_state;
      emb_q <= status_lane_emb_state;
      ifs_ready_q <= status_lane_ifs_ready;
      latency_q <= status_lane_latency;
      align_err_q <= status_lane_align_err_cnt;
      err_stats_q <= status_err_stats_cnt;
      ilas_valid_q <= ilas_valid;
      ilas_addr_q <= ilas_addr;
      ilas_data_q <= ilas_data;
    end
  end

  // split the packed vectors into one interface per lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_split
    assign lanes[i].cgs_state = cgs_state_e'(cgs_q[2*i +: 2]);
    assign lanes[i].emb_state = emb_q[3*i +: 3];
    assign lanes[i].ifs_ready = ifs_ready_q[i];
    assign lanes[i].latency = latency_q[14*i +: 14];
    assign lanes[i].align_err_cnt = align_err_q[8*i +: 8];
    assign lanes[i].err_stats_cnt = err_stats_q[32*i +: 32];
    assign lanes[i].ilas_valid = ilas_valid_q[i];
    assign lanes[i].ilas_addr = ilas_addr_q[2*i +: 2];
    assign lanes[i].ilas_data = ilas_data_q[32*i +: 32];

    // a strobed ILAS word must name a real slot
    a_ilas_addr_known: assert property (@(posedge up_clk) disable iff (up_reset)
      ilas_valid[i] |-> !$isunknown(ilas_addr[2*i +: 2]));
  end

endmodule

/* tb.f */
logic/jesd_rx_regs_pkg.sv
logic/lane_status_if.sv
logic/rx_status_capture.sv
logic/rx_lane_regs.sv
logic/rx_common_regs.sv
logic/rx_read_mux.sv
logic/jesd_rx_up_top.sv
tests/tb_top.sv

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  import jesd_rx_regs_pkg::*;

  logic up_clk;
  logic up_reset;
  logic up_rreq;
  logic [11:0] up_raddr;
  logic [31:0] up_rdata;
  logic up_wreq;
  logic [11:0] up_waddr;
  logic [31:0] up_wdata;
  logic cfg_is_writeable;
  logic cfg_buffer_early_release;
  logic [7:0] cfg_buffer_delay;
  logic [8:0] err_stats_mask;
  logic err_stats_reset;
  logic [7:0] cfg_align_err_threshold;
  rx_ctrl_state_e status_ctrl_state;
  logic [2*NUM_LANES-1:0] status_lane_cgs_state;
  logic [3*NUM_LANES-1:0] status_lane_emb_state;
  logic [NUM_LANES-1:0] status_lane_ifs_ready;
  logic [14*NUM_LANES-1:0] status_lane_latency;
  logic [8*NUM_LANES-1:0] status_lane_align_err_cnt;
  logic [32*NUM_LANES-1:0] status_err_stats_cnt;
  logic [NUM_LANES-1:0] ilas_valid;
  logic [2*NUM_LANES-1:0] ilas_addr;
  logic [32*NUM_LANES-1:0] ilas_data;

  // register model
  logic m_early;
  logic [7:0] m_delay;
  logic [8:0] m_mask;
  logic m_sreset;
  logic [7:0] m_thresh;
  logic [1:0] m_ctrl;
  logic [1:0] m_cgs [NUM_LANES];
  logic [2:0] m_emb [NUM_LANES];
  logic m_ifs [NUM_LANES];
  logic [13:0] m_lat [NUM_LANES];
  logic [7:0] m_aerr [NUM_LANES];
  logic [31:0] m_estats [NUM_LANES];
  logic [31:0] m_ilas [NUM_LANES][4];

  logic [31:0] lfsr_state = 32'h7c19ca5f;
  int test_num = 0;
  int test_checks = 0;
  int test_errors = 0;
  int total_checks = 0;
  int total_errors = 0;

  jesd_rx_up_top dut0 (.*);

  initial begin
    up_clk = 1'b0;
    forever #2 up_clk = ~up_clk;
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic tick();
    @(posedge up_clk);
    #1;
  endtask

  task automatic note_timeout(input string why);
    $display("%s", why);
    test_errors++;
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    test_checks++;
    assert (got === exp) else begin
      $display("Error at %0d ns: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %0d checks, %0d errors", test_num, name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    up_wreq = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    tick();
    up_wreq = 1'b0;
  endtask

  // read data is loaded on the request edge and sampled 1 ns later
  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp);
    up_rreq = 1'b1;
    up_raddr = addr;
    tick();
    up_rreq = 1'b0;
    check_equal(up_rdata, exp, $sformatf("read 0x%03h", addr));
  endtask

  task automatic check_cfg_ports();
    check_equal(32'(cfg_buffer_early_release), 32'(m_early), "cfg_buffer_early_release");
    check_equal(32'(cfg_buffer_delay), 32'(m_delay), "cfg_buffer_delay");
    check_equal(32'(err_stats_mask), 32'(m_mask), "err_stats_mask");
    check_equal(32'(err_stats_reset), 32'(m_sreset), "err_stats_reset");
    check_equal(32'(cfg_align_err_threshold), 32'(m_thresh), "cfg_align_err_threshold");
  endtask

  function automatic logic [31:0] buf_cfg_word();
    return (32'(m_early) << 16) | (32'(m_delay) << 2);
  endfunction

  function automatic logic [31:0] err_stats_word();
    return (32'(m_mask) << 8) | 32'(m_sreset);
  endfunction

  function automatic logic [11:0] lane_addr(input int lane, input int offset);
    return 12'h0c0 + 12'(8 * lane + offset);
  endfunction

  task automatic apply_status();
    status_ctrl_state = rx_ctrl_state_e'(m_ctrl);
    for (int l = 0; l < NUM_LANES; l++) begin
      status_lane_cgs_state[2*l +: 2] = m_cgs[l];
      status_lane_emb_state[3*l +: 3] = m_emb[l];
      status_lane_ifs_ready[l] = m_ifs[l];
      status_lane_latency[14*l +: 14] = m_lat[l];
      status_lane_align_err_cnt[8*l +: 8] = m_aerr[l];
      status_err_stats_cnt[32*l +: 32] = m_estats[l];
    end
  endtask

  task automatic wait_reset_values();
    int n;
    n = 0;
    while (!(cfg_align_err_threshold == 8'd4 && up_rdata == 32'd0) && n < 20) begin
      tick();
      n++;
    end
    if (n >= 20) begin
      note_timeout("timeout: the DUT never showed its reset values after reset was released");
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [11:0] addr;
    int lane;
    int slot;
    int found;
    int tries;
    up_reset = 1'b1;
    up_rreq = 1'b0;
    up_raddr = '0;
    up_wreq = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    cfg_is_writeable = 1'b0;
    ilas_valid = '0;
    ilas_addr = '0;
    ilas_data = '0;
    m_early = 1'b0;
    m_delay = '0;
    m_mask = '0;
    m_sreset = 1'b0;
    m_thresh = 8'd4;
    m_ctrl = 2'd0;
    for (int l = 0; l < NUM_LANES; l++) begin
      m_cgs[l] = '0;
      m_emb[l] = '0;
      m_ifs[l] = 1'b0;
      m_lat[l] = '0;
      m_aerr[l] = '0;
      m_estats[l] = '0;
      for (int w = 0; w < 4; w++) begin
        m_ilas[l][w] = '0;
      end
    end
    apply_status();
    repeat (16) @(posedge up_clk);
    #1;
    up_reset = 1'b0;
    wait_reset_values();

    // the controller state is the only status that moves here
    m_ctrl = 2'(take_bits(2));
    apply_status();
    tick();
    tick();
    read_check(ADDR_BUF_SIZE, 32'd256);
    read_check(ADDR_BUF_CFG, 32'd0);
    read_check(ADDR_ERR_STATS, 32'd0);
    read_check(ADDR_ALIGN_THRESH, 32'd4);
    read_check(ADDR_CTRL_STATE, 32'(m_ctrl));
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int o = 0; o < 8; o++) begin
        read_check(lane_addr(l, o), 32'd0);
      end
    end
    check_cfg_ports();
    finish_test("reset values");

    for (int i = 0; i < 24; i++) begin
      cfg_is_writeable = 1'(take_bits(1));
      data = take_bits(32);
      write_reg(ADDR_BUF_CFG, data);
      if (cfg_is_writeable) begin
        m_early = data[16];
        m_delay = data[9:2];
      end
      check_cfg_ports();
      read_check(ADDR_BUF_CFG, buf_cfg_word());
    end
    finish_test("writeable gating");

    for (int i = 0; i < 24; i++) begin
      cfg_is_writeable = 1'(take_bits(1));
      data = take_bits(32);
      if (take_bits(1)) begin
        write_reg(ADDR_ERR_STATS, data);
        m_mask = data[16:8];
        m_sreset = data[0];
      end else begin
        write_reg(ADDR_ALIGN_THRESH, data);
        m_thresh = data[7:0];
      end
      check_cfg_ports();
      read_check(ADDR_ERR_STATS, err_stats_word());
      read_check(ADDR_ALIGN_THRESH, 32'(m_thresh));
    end
    finish_test("always writable registers");

    for (int r = 0; r < 6; r++) begin
      m_ctrl = 2'(take_bits(2));
      for (int l = 0; l < NUM_LANES; l++) begin
        // sync state encoding 3 never occurs on a real link
        m_cgs[l] = 2'(take_bits(2) % 3);
        m_emb[l] = 3'(take_bits(3));
        m_ifs[l] = 1'(take_bits(1));
        m_lat[l] = 14'(take_bits(14));
        m_aerr[l] = 8'(take_bits(8));
        m_estats[l] = take_bits(32);
      end
      apply_status();
      tick();
      tick();
      read_check(ADDR_CTRL_STATE, 32'(m_ctrl));
      for (int l = 0; l < NUM_LANES; l++) begin
        read_check(lane_addr(l, 0),
                   32'(m_cgs[l]) | (32'(m_ifs[l]) << 4) | (32'(m_emb[l]) << 8));
        read_check(lane_addr(l, 1), 32'(m_lat[l]));
        read_check(lane_addr(l, 2), m_estats[l]);
        read_check(lane_addr(l, 3), 32'(m_aerr[l]));
      end
    end
    finish_test("lane status");

    for (int i = 0; i < 32; i++) begin
      lane = int'(take_bits(2));
      slot = int'(take_bits(2));
      data = take_bits(32);
      ilas_valid = '0;
      ilas_valid[lane] = 1'b1;
      ilas_addr[2*lane +: 2] = 2'(slot);
      ilas_data[32*lane +: 32] = data;
      m_ilas[lane][slot] = data;
      tick();
      ilas_valid = '0;
    end
    tick();
    tick();
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int w = 0; w < 4; w++) begin
        read_check(lane_addr(l, 4 + w), m_ilas[l][w]);
      end
    end
    finish_test("ILAS store");

    found = 0;
    tries = 0;
    while (found < 24 && tries < 1000) begin
      addr = 12'(take_bits(12));
      tries++;
      if (addr != ADDR_BUF_SIZE && addr != ADDR_BUF_CFG && addr != ADDR_ERR_STATS &&
          addr != ADDR_ALIGN_THRESH && addr != ADDR_CTRL_STATE &&
          !(addr >= 12'h0c0 && addr <= 12'h0df)) begin
        read_check(addr, 32'd0);
        found++;
      end
    end
    if (found < 24) begin
      note_timeout("timeout: could not draw enough unmapped read addresses");
    end
    finish_test("unmapped addresses");

    $display("tests run: %0d, checks: %0d, errors: %0d", test_num, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
